// File: Makefile
# Verilator build and run of the decode/execute testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_execute
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

PASS_TEXT = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/decode_execute_top.sv
`timescale 1ns/1ns
`default_nettype none

module decode_execute_top import rv_pkg::*; (
    input  wire            clk_i,
    input  wire            rst_n_i,
    input  wire word_t     instr_i,
    input  wire word_t     pc_i,
    input  wire            stall_i,
    input  wire            flush_i,
    input  wire            wb_en_i,
    input  wire reg_addr_t wb_addr_i,
    input  wire word_t     wb_data_i,
    output ex_result_t     ex_result_o,
    output logic           branch_taken_o,
    output word_t          branch_target_o
);

    ctrl_t     ctrl_d;
    ctrl_t     ctrl_e;
    de_data_t  data_d;
    de_data_t  data_e;
    reg_addr_t rd_addr1_d;
    reg_addr_t rd_addr2_d;
    reg_addr_t wr_addr_d;
    word_t     rd_data1_d;
    word_t     rd_data2_d;
    word_t     imm_ext_d;
    word_t     pc_plus_4_d;
    logic      flush_int;

    // Taken branch or jump kills the instruction now in decode
    assign flush_int = flush_i | branch_taken_o;

    instr_decoder i_decoder (
        .instr_i     (instr_i),
        .pc_i        (pc_i),
        .ctrl_o      (ctrl_d),
        .rd_addr1_o  (rd_addr1_d),
        .rd_addr2_o  (rd_addr2_d),
        .wr_addr_o   (wr_addr_d),
        .imm_ext_o   (imm_ext_d),
        .pc_plus_4_o (pc_plus_4_d)
    );

    reg_file i_reg_file (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rd_addr1_i (rd_addr1_d),
        .rd_addr2_i (rd_addr2_d),
        .rd_data1_o (rd_data1_d),
        .rd_data2_o (rd_data2_d),
        .wr_en_i    (wb_en_i),
        .wr_addr_i  (wb_addr_i),
        .wr_data_i  (wb_data_i)
    );

    always_comb begin
        data_d.rd_data1  = rd_data1_d;
        data_d.rd_data2  = rd_data2_d;
        data_d.rd_addr1  = rd_addr1_d;
        data_d.rd_addr2  = rd_addr2_d;
        data_d.wr_addr   = wr_addr_d;
        data_d.imm_ext   = imm_ext_d;
        data_d.pc        = pc_i;
        data_d.pc_plus_4 = pc_plus_4_d;
    end

    pipeline_reg_d_e i_pipe_d_e (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_int),
        .stall_i  (stall_i),
        .ctrl_d_i (ctrl_d),
        .data_d_i (data_d),
        .ctrl_e_o (ctrl_e),
        .data_e_o (data_e)
    );

    execute_stage i_execute (
        .ctrl_e_i        (ctrl_e),
        .data_e_i        (data_e),
        .ex_result_o     (ex_result_o),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o)
    );

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_config.svh"

module execute_stage import rv_pkg::*; (
    input  wire ctrl_t    ctrl_e_i,
    input  wire de_data_t data_e_i,
    output ex_result_t    ex_result_o,
    output logic          branch_taken_o,
    output word_t         branch_target_o
);

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    word_t              op_a;
    word_t              op_b;
    word_t              alu_res;
    logic [SHAMT_W-1:0] shamt;
    logic               cond_met;
    logic [1:0]         byte_off;
    byte_en_t           size_mask;

    assign op_a  = ctrl_e_i.alu_src_a_pc ? data_e_i.pc : data_e_i.rd_data1;
    assign op_b  = ctrl_e_i.alu_src_imm ? data_e_i.imm_ext : data_e_i.rd_data2;
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb begin
        alu_res = '0;
        case (ctrl_e_i.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res[0] = $signed(op_a) < $signed(op_b);
            ALU_SLTU:   alu_res[0] = op_a < op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // Branch condition on the raw register values
    always_comb begin
        case (ctrl_e_i.funct3)
            3'b000:  cond_met = data_e_i.rd_data1 == data_e_i.rd_data2;
            3'b001:  cond_met = data_e_i.rd_data1 != data_e_i.rd_data2;
            3'b100:  cond_met = $signed(data_e_i.rd_data1) < $signed(data_e_i.rd_data2);
            3'b101:  cond_met = $signed(data_e_i.rd_data1) >= $signed(data_e_i.rd_data2);
            3'b110:  cond_met = data_e_i.rd_data1 < data_e_i.rd_data2;
            3'b111:  cond_met = data_e_i.rd_data1 >= data_e_i.rd_data2;
            default: cond_met = 1'b0;
        endcase
    end

    assign branch_taken_o = (ctrl_e_i.branch && cond_met) || ctrl_e_i.jump;

    // JALR target has bit 0 cleared
    assign branch_target_o = ctrl_e_i.jalr
                           ? ((data_e_i.rd_data1 + data_e_i.imm_ext) & ~32'd1)
                           : (data_e_i.pc + data_e_i.imm_ext);

    // Store lanes from size and low address bits
    assign byte_off = alu_res[1:0];

    always_comb begin
        case (ctrl_e_i.funct3[1:0])
            2'b00:   size_mask = 4'b0001;
            2'b01:   size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    always_comb begin
        ex_result_o            = '0;
        ex_result_o.reg_wr_en  = ctrl_e_i.reg_wr_en;
        ex_result_o.wr_addr    = data_e_i.wr_addr;
        ex_result_o.wr_value   = ctrl_e_i.result_pc4 ? data_e_i.pc_plus_4 : alu_res;
        ex_result_o.mem_wr_en  = ctrl_e_i.mem_wr_en;
        ex_result_o.load_flag  = ctrl_e_i.load_flag;
        ex_result_o.mem_addr   = alu_res;
        if (ctrl_e_i.mem_wr_en) begin
            ex_result_o.store_data = data_e_i.rd_data2 << {byte_off, 3'b000};
            ex_result_o.byte_en    = size_mask << byte_off;
        end
    end

endmodule

`default_nettype wire

// File: hdl/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decoder import rv_pkg::*; (
    input  wire word_t instr_i,
    input  wire word_t pc_i,
    output ctrl_t      ctrl_o,
    output reg_addr_t  rd_addr1_o,
    output reg_addr_t  rd_addr2_o,
    output reg_addr_t  wr_addr_o,
    output word_t      imm_ext_o,
    output word_t      pc_plus_4_o
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0] opcode;
    funct3_t    funct3;
    logic       funct7_b5;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    // SUB exists only in the register-register form
    function automatic alu_op_t alu_op_of(input funct3_t f3, input logic f7_b5,
                                          input logic reg_reg);
        alu_op_t op;
        case (f3)
            3'b000:  op = (reg_reg && f7_b5) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = f7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    assign rd_addr1_o = instr_i[19:15];
    assign rd_addr2_o = instr_i[24:20];
    assign wr_addr_o  = instr_i[11:7];

    // Immediate formats, all sign extended from bit 31
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    assign pc_plus_4_o = pc_i + 32'd4;

    always_comb begin
        ctrl_o    = '0;
        imm_ext_o = '0;
        case (opcode)
            OPC_OP: begin
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.alu_op    = alu_op_of(funct3, funct7_b5, 1'b1);
            end
            OPC_OP_IMM: begin
                ctrl_o.reg_wr_en   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = alu_op_of(funct3, funct7_b5, 1'b0);
                imm_ext_o          = imm_i;
            end
            OPC_LUI: begin
                ctrl_o.reg_wr_en   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = ALU_PASS_B;
                imm_ext_o          = imm_u;
            end
            OPC_AUIPC: begin
                ctrl_o.reg_wr_en    = 1'b1;
                ctrl_o.alu_src_imm  = 1'b1;
                ctrl_o.alu_src_a_pc = 1'b1;
                imm_ext_o           = imm_u;
            end
            OPC_LOAD: begin
                ctrl_o.reg_wr_en   = 1'b1;
                ctrl_o.load_flag   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.funct3      = funct3;
                imm_ext_o          = imm_i;
            end
            OPC_STORE: begin
                ctrl_o.mem_wr_en   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.funct3      = funct3;
                imm_ext_o          = imm_s;
            end
            OPC_BRANCH: begin
                ctrl_o.branch = 1'b1;
                ctrl_o.funct3 = funct3;
                imm_ext_o     = imm_b;
            end
            OPC_JAL: begin
                ctrl_o.reg_wr_en  = 1'b1;
                ctrl_o.jump       = 1'b1;
                ctrl_o.result_pc4 = 1'b1;
                imm_ext_o         = imm_j;
            end
            OPC_JALR: begin
                ctrl_o.reg_wr_en   = 1'b1;
                ctrl_o.jump        = 1'b1;
                ctrl_o.jalr        = 1'b1;
                ctrl_o.result_pc4  = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                imm_ext_o          = imm_i;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/pipeline_reg_d_e.sv
`timescale 1ns/1ns
`default_nettype none

module pipeline_reg_d_e import rv_pkg::*; (
    input  wire           clk_i,
    input  wire           rst_n_i,
    input  wire           flush_i,
    input  wire           stall_i,

    // Decode side
    input  wire ctrl_t    ctrl_d_i,
    input  wire de_data_t data_d_i,

    // Execute side
    output ctrl_t         ctrl_e_o,
    output de_data_t      data_e_o
);

    // Reset and flush both leave a bubble, flush wins over stall
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            ctrl_e_o <= '0;
            data_e_o <= '0;
        end else if (!stall_i) begin
            ctrl_e_o <= ctrl_d_i;
            data_e_o <= data_d_i;
        end
    end

    // Held contents after a stall edge
    a_stall_hold: assert property (
        @(posedge clk_i)
        (rst_n_i && stall_i && !flush_i) |=> ($stable(ctrl_e_o) && $stable(data_e_o))
    ) else $error("pipeline_reg_d_e: contents changed during stall");

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_config.svh"

module reg_file import rv_pkg::*; (
    input  wire            clk_i,
    input  wire            rst_n_i,
    input  wire reg_addr_t rd_addr1_i,
    input  wire reg_addr_t rd_addr2_i,
    output word_t          rd_data1_o,
    output word_t          rd_data2_o,
    input  wire            wr_en_i,
    input  wire reg_addr_t wr_addr_i,
    input  wire word_t     wr_data_i
);

    // x0 has no storage
    word_t regs [1:`RV_REG_COUNT-1];

    // Write in the same cycle is seen by the read
    function automatic word_t read_port(input reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en_i && (wr_addr_i == addr)) begin
            value = wr_data_i;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    always_comb begin
        rd_data1_o = read_port(rd_addr1_i);
        rd_data2_o = read_port(rd_addr2_i);
    end

endmodule

`default_nettype wire

// File: hdl/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Machine word, RV32I only
`define RV_XLEN 32

// Architectural register file
`define RV_REG_ADDR_W 5
`define RV_REG_COUNT 32

// ALU operation code width
`define RV_ALU_OP_W 4

// One store lane per byte of the word
`define RV_BYTE_EN_W (`RV_XLEN / 8)

// funct3 field of the instruction
`define RV_FUNCT3_W 3

`endif

// File: hdl/rv_pkg.sv
`default_nettype none

`include "rv_core_config.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]      word_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`RV_ALU_OP_W-1:0]   alu_op_t;
    typedef logic [`RV_BYTE_EN_W-1:0]  byte_en_t;
    typedef logic [`RV_FUNCT3_W-1:0]   funct3_t;

    // ADD must stay zero so that a bubble computes 0 + 0
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;

    typedef struct packed {
        logic    reg_wr_en;
        logic    mem_wr_en;
        logic    load_flag;
        logic    branch;
        logic    jump;
        logic    jalr;
        logic    alu_src_imm;
        logic    alu_src_a_pc;
        logic    result_pc4;
        alu_op_t alu_op;
        funct3_t funct3;
    } ctrl_t;

    typedef struct packed {
        word_t     rd_data1;
        word_t     rd_data2;
        reg_addr_t rd_addr1;
        reg_addr_t rd_addr2;
        reg_addr_t wr_addr;
        word_t     imm_ext;
        word_t     pc;
        word_t     pc_plus_4;
    } de_data_t;

    typedef struct packed {
        logic      reg_wr_en;
        reg_addr_t wr_addr;
        // ALU result or link value
        word_t     wr_value;
        logic      mem_wr_en;
        logic      load_flag;
        word_t     mem_addr;
        word_t     store_data;
        byte_en_t  byte_en;
    } ex_result_t;

endpackage

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/pipeline_reg_d_e.sv
hdl/execute_stage.sv
hdl/decode_execute_top.sv
test/tb_decode_execute.sv

// File: test/tb_decode_execute.sv
`timescale 1ns/1ns
`default_nettype none

module tb_decode_execute import rv_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int N_ALU      = 40;
    localparam int N_MEM      = 30;
    localparam int N_STALL    = 4;
    localparam int MAX_STALL  = 6;
    localparam int N_BYP      = 8;
    // Every step is one clock, idle steps and flush cases included
    localparam int MAX_STEPS  = 33 + N_ALU + 2 * N_MEM + 4 * 18 + 3 * 6
                              + N_STALL * (MAX_STALL + 2) + 2 * N_BYP + 60;
    localparam int TIMEOUT_NS = (MAX_STEPS + 100) * CLK_PERIOD;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef struct packed {
        ex_result_t res;
        logic       taken;
        word_t      target;
    } exp_t;

    logic       clk_i;
    logic       rst_n_i;
    logic       stall_i;
    logic       flush_i;
    logic       wb_en_i;
    word_t      instr_i;
    word_t      pc_i;
    reg_addr_t  wb_addr_i;
    word_t      wb_data_i;
    ex_result_t ex_result_o;
    logic       branch_taken_o;
    word_t      branch_target_o;

    // Shadow of the architectural registers
    word_t shadow [32];
    exp_t  last_exp;
    exp_t  next_exp;
    exp_t  due_exp;
    logic  next_valid;
    logic  due_valid;
    int    checks;
    int    errors;

    decode_execute_top i_dut (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .instr_i         (instr_i),
        .pc_i            (pc_i),
        .stall_i         (stall_i),
        .flush_i         (flush_i),
        .wb_en_i         (wb_en_i),
        .wb_addr_i       (wb_addr_i),
        .wb_data_i       (wb_data_i),
        .ex_result_o     (ex_result_o),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // Random OP, OP-IMM, LUI or AUIPC with legal shift encodings
    function automatic word_t rand_alu();
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        reg_addr_t   rd;
        f3  = 3'($urandom_range(0, 7));
        imm = 12'($urandom);
        rd  = 5'($urandom_range(0, 31));
        f7  = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, 1'($urandom), 5'b0} : 7'b0;
        case ($urandom_range(0, 3))
            0: return enc_r(f7, 5'($urandom), 5'($urandom), f3, rd);
            1: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm[11:5] = (f3 == 3'b101) ? f7 : 7'b0;
                end
                return enc_i(imm, 5'($urandom), f3, rd, OPC_OP_IMM);
            end
            2: return {20'($urandom), rd, OPC_LUI};
            default: return {20'($urandom), rd, OPC_AUIPC};
        endcase
    endfunction

    // Expected execute outputs, decoded from the instruction set rules
    function automatic exp_t exp_result(input word_t instr, input word_t pc,
                                        input word_t regs [32]);
        exp_t       e;
        logic [6:0] opc;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      opa;
        word_t      opb;
        word_t      alu;
        logic       use_imm;
        logic [4:0] sh;
        logic [1:0] off;
        logic [3:0] mask;
        opc     = instr[6:0];
        f3      = instr[14:12];
        a       = regs[instr[19:15]];
        b       = regs[instr[24:20]];
        e       = '0;
        imm     = '0;
        use_imm = 1'b1;
        case (opc)
            OPC_OP: use_imm = 1'b0;
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: imm = {{20{instr[31]}}, instr[31:20]};
            OPC_STORE: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OPC_LUI, OPC_AUIPC: imm = {instr[31:12], 12'b0};
            OPC_BRANCH: begin
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                use_imm = 1'b0;
            end
            OPC_JAL: begin
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                use_imm = 1'b0;
            end
            default: return '0;
        endcase
        opa = (opc == OPC_AUIPC) ? pc : a;
        opb = use_imm ? imm : b;
        sh  = opb[4:0];
        alu = opa + opb;
        if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            case (f3)
                3'b000: alu = (opc == OPC_OP && instr[30]) ? opa - opb : opa + opb;
                3'b001: alu = opa << sh;
                3'b010: alu = {31'b0, $signed(opa) < $signed(opb)};
                3'b011: alu = {31'b0, opa < opb};
                3'b100: alu = opa ^ opb;
                3'b101: alu = instr[30] ? word_t'($signed(opa) >>> sh) : opa >> sh;
                3'b110: alu = opa | opb;
                default: alu = opa & opb;
            endcase
        end
        if (opc == OPC_LUI) begin
            alu = imm;
        end
        e.res.wr_addr   = instr[11:7];
        e.res.wr_value  = alu;
        e.res.mem_addr  = alu;
        e.res.reg_wr_en = (opc != OPC_STORE) && (opc != OPC_BRANCH);
        e.res.load_flag = (opc == OPC_LOAD);
        e.res.mem_wr_en = (opc == OPC_STORE);
        if (opc == OPC_STORE) begin
            off  = alu[1:0];
            mask = (f3[1:0] == 2'b00) ? 4'b0001 : (f3[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
            e.res.store_data = b << (8 * off);
            e.res.byte_en    = mask << off;
        end
        if (opc == OPC_BRANCH) begin
            case (f3)
                3'b000: e.taken = (a == b);
                3'b001: e.taken = (a != b);
                3'b100: e.taken = ($signed(a) < $signed(b));
                3'b101: e.taken = ($signed(a) >= $signed(b));
                3'b110: e.taken = (a < b);
                default: e.taken = (a >= b);
            endcase
            e.target = pc + imm;
        end
        if (opc == OPC_JAL || opc == OPC_JALR) begin
            e.taken          = 1'b1;
            e.target         = (opc == OPC_JAL) ? pc + imm : (a + imm) & ~32'd1;
            e.res.wr_value   = pc + 32'd4;
        end
        return e;
    endfunction

    task automatic check_result(input ex_result_t got, input ex_result_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: ex_result %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_branch(input logic got_taken, input word_t got_target,
                                input logic exp_taken, input word_t exp_target);
        checks++;
        if (got_taken !== exp_taken) begin
            errors++;
            $display("Fail %0t: branch taken %b, expected %b", $time, got_taken, exp_taken);
        end else if (exp_taken && got_target !== exp_target) begin
            errors++;
            $display("Fail %0t: target %h, expected %h", $time, got_target, exp_target);
        end
    endtask

    // Outputs settle one full cycle after an instruction is driven
    initial begin
        due_valid = 1'b0;
        forever begin
            @(negedge clk_i);
            if (due_valid) begin
                check_result(ex_result_o, due_exp.res);
                check_branch(branch_taken_o, branch_target_o, due_exp.taken, due_exp.target);
            end
            due_valid  = next_valid;
            due_exp    = next_exp;
            next_valid = 1'b0;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog timeout: the tests did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    // One clock of stimulus and its expected result
    task automatic step(input word_t instr, input word_t pc, input logic stall,
                        input logic flush, input logic rst, input logic wb_en,
                        input reg_addr_t wb_addr, input word_t wb_data);
        exp_t e;
        @(posedge clk_i);
        instr_i   <= instr;
        pc_i      <= pc;
        stall_i   <= stall;
        flush_i   <= flush;
        rst_n_i   <= !rst;
        wb_en_i   <= wb_en;
        wb_addr_i <= wb_addr;
        wb_data_i <= wb_data;
        if (wb_en && wb_addr != '0) begin
            shadow[wb_addr] = wb_data;
        end
        if (rst) begin
            foreach (shadow[i]) shadow[i] = '0;
        end
        if (rst || flush || last_exp.taken) begin
            e = '0;
        end else if (stall) begin
            e = last_exp;
        end else begin
            e = exp_result(instr, pc, shadow);
        end
        next_exp   = e;
        next_valid = 1'b1;
        last_exp   = e;
    endtask

    task automatic issue(input word_t instr, input word_t pc);
        step(instr, pc, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        step('0, '0, 1'b0, 1'b0, 1'b0, 1'b1, addr, data);
    endtask

    task automatic finish_test(input string name, input int c0, input int e0);
        issue('0, '0);
        issue('0, '0);
        $display("Test %s done: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    function automatic word_t rand_pc();
        return $urandom & ~32'd3;
    endfunction

    initial begin
        int          c0;
        int          e0;
        int          n;
        logic [2:0]  f3;
        logic [11:0] imm;
        reg_addr_t   r;
        word_t       a;
        word_t       b;
        word_t       pc;
        logic [2:0]  br_f3 [6];
        br_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        void'($urandom(32'h7c35_ae3e));
        rst_n_i    = 1'b0;
        stall_i    = 1'b0;
        flush_i    = 1'b0;
        wb_en_i    = 1'b0;
        instr_i    = '0;
        pc_i       = '0;
        wb_addr_i  = '0;
        wb_data_i  = '0;
        checks     = 0;
        errors     = 0;
        next_valid = 1'b0;
        last_exp   = '0;
        foreach (shadow[i]) shadow[i] = '0;
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;

        c0 = checks;
        e0 = errors;
        // The write to x0 must be discarded
        for (int i = 0; i < 32; i++) begin
            write_reg(5'(i), $urandom);
        end
        // x0 reads zero, also while it is being written
        step(enc_r(7'b0, 5'd0, 5'd0, 3'b110, 5'd1), rand_pc(), 1'b0, 1'b0, 1'b0,
             1'b1, 5'd0, $urandom);
        for (int i = 0; i < N_ALU; i++) begin
            issue(rand_alu(), rand_pc());
        end
        finish_test("alu", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_MEM; i++) begin
            r = 5'($urandom_range(1, 31));
            write_reg(r, $urandom & ~32'd3);
            f3  = 3'($urandom_range(0, 2));
            imm = 12'($urandom) & ~((12'd1 << f3) - 12'd1);
            if ($urandom_range(0, 1) == 0) begin
                issue(enc_s(imm, 5'($urandom), r, f3), rand_pc());
            end else begin
                f3 = ($urandom_range(0, 1) && f3 != 3'b010) ? f3 | 3'b100 : f3;
                issue(enc_i(imm, r, f3, 5'($urandom), OPC_LOAD), rand_pc());
            end
        end
        finish_test("load_store", c0, e0);

        c0 = checks;
        e0 = errors;
        foreach (br_f3[k]) begin
            for (int rel = 0; rel < 3; rel++) begin
                a = $urandom;
                b = (rel == 0) ? a : (rel == 1) ? a + $urandom_range(1, 1000)
                                                : a - $urandom_range(1, 1000);
                write_reg(5'd5, a);
                write_reg(5'd6, b);
                pc = rand_pc();
                issue(enc_b({12'($urandom), 1'b0}, 5'd6, 5'd5, br_f3[k]), pc);
                issue(rand_alu(), pc + 32'd4);
            end
        end
        for (int i = 0; i < 3; i++) begin
            write_reg(5'd7, $urandom);
            pc = rand_pc();
            issue(enc_j({20'($urandom), 1'b0}, 5'($urandom)), pc);
            issue(rand_alu(), pc + 32'd4);
            issue(enc_i(12'($urandom), 5'd7, 3'b000, 5'($urandom), OPC_JALR), pc);
            issue(rand_alu(), pc + 32'd4);
        end
        finish_test("branch_jump", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_STALL; i++) begin
            issue(rand_alu(), rand_pc());
            n = $urandom_range(1, MAX_STALL);
            repeat (n) step(rand_alu(), rand_pc(), 1'b1, 1'b0, 1'b0, 1'b0, '0, '0);
            issue(rand_alu(), rand_pc());
        end
        finish_test("stall", c0, e0);

        c0 = checks;
        e0 = errors;
        issue(rand_alu(), rand_pc());
        step(rand_alu(), rand_pc(), 1'b0, 1'b1, 1'b0, 1'b0, '0, '0);
        issue(rand_alu(), rand_pc());
        step(rand_alu(), rand_pc(), 1'b1, 1'b1, 1'b0, 1'b0, '0, '0);
        step(rand_alu(), rand_pc(), 1'b1, 1'b0, 1'b0, 1'b0, '0, '0);
        issue(rand_alu(), rand_pc());
        step(rand_alu(), rand_pc(), 1'b0, 1'b0, 1'b1, 1'b0, '0, '0);
        // Register file is cleared as well
        issue(enc_r(7'b0, 5'd3, 5'd2, 3'b000, 5'd1), rand_pc());
        finish_test("flush_reset", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_BYP; i++) begin
            r = 5'($urandom_range(1, 31));
            write_reg(r, $urandom);
            step(enc_r(7'b0, r, r, 3'b000, 5'd9), rand_pc(), 1'b0, 1'b0, 1'b0,
                 1'b1, r, $urandom);
        end
        finish_test("bypass", c0, e0);

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
